/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_status_display
FILELIST = build.f
BUILD    = obj_dir
SIM      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(wildcard design/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* build.f */
+incdir+verif
design/board_status_pkg.sv
design/seg_scan_if.sv
design/key_history_select.sv
design/seg_digit_scan.sv
design/seg_glyph_driver.sv
design/status_led_ctrl.sv
design/status_display_top.sv
verif/tb_status_display.sv

/* design/board_status_pkg.sv */
/*
 * board status package
 * display, glyph, privilege and LED types shared by the front-panel
 * status unit, plus the hex font and the two banner tables
 */
package board_status_pkg;

    // segment bits, decimal point on top, active high inside the design
    typedef logic [7:0] seg_t;
    // one enable per digit, active low
    typedef logic [7:0] anode_t;
    typedef logic [3:0] nibble_t;
    typedef logic [2:0] digit_t;
    typedef logic [31:0] disp_word_t;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_t;

    typedef struct packed {
        logic blue;
        logic green;
        logic red;
    } rgb_t;

    localparam int PWM_W = 12;
    localparam int BLINK_W = 4;

    // letters for the banners, segments a..g in bits 6..0
    localparam seg_t GLYPH_BLANK = 8'b0000_0000;
    localparam seg_t GLYPH_DOT   = 8'b1000_0000;
    localparam seg_t GLYPH_CAP_A = 8'b0111_0111;
    localparam seg_t GLYPH_R     = 8'b0000_0101;
    localparam seg_t GLYPH_C     = 8'b0000_1101;
    localparam seg_t GLYPH_H     = 8'b0001_0111;
    localparam seg_t GLYPH_CAP_P = 8'b0110_0111;
    localparam seg_t GLYPH_O     = 8'b0001_1101;
    localparam seg_t GLYPH_CAP_L = 8'b0000_1110;
    localparam seg_t GLYPH_A     = 8'b0111_1101;
    localparam seg_t GLYPH_D     = 8'b0011_1101;
    localparam seg_t GLYPH_I     = 8'b0001_0000;
    localparam seg_t GLYPH_N     = 8'b0001_0101;
    // g carries the dot as its tail
    localparam seg_t GLYPH_G     = 8'b1111_1011;

    localparam seg_t HEX_FONT [16] = '{
        8'b0111_1110, 8'b0011_0000, 8'b0110_1101, 8'b0111_1001,
        8'b0011_0011, 8'b0101_1011, 8'b0101_1111, 8'b0111_0000,
        8'b0111_1111, 8'b0111_1011, 8'b0111_0111, 8'b0001_1111,
        8'b0100_1110, 8'b0011_1101, 8'b0100_1111, 8'b0100_0111
    };

    // "ArchProc", digit 0 is the rightmost
    localparam seg_t INIT_BANNER [8] = '{
        GLYPH_C, GLYPH_O, GLYPH_R, GLYPH_CAP_P,
        GLYPH_H, GLYPH_C, GLYPH_R, GLYPH_CAP_A
    };

    // scrolled through the display while memory is initialized
    localparam seg_t LOAD_BANNER [16] = '{
        GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK,
        GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK, GLYPH_CAP_L,
        GLYPH_O,     GLYPH_A,     GLYPH_D,     GLYPH_I,
        GLYPH_N,     GLYPH_G,     GLYPH_DOT,   GLYPH_DOT
    };

endpackage

/* design/key_history_select.sv */
/*
 * key history and display word select
 * keeps the last two keyboard and mouse bytes and picks the word shown
 * on the display from the push buttons
 */
`timescale 1ns/1ns

module key_history_select (
    input  logic                         core_clk,
    input  logic                         core_rst_x,
    input  logic                         kbd_we,
    input  logic [7:0]                   kbd_data,
    input  logic                         mouse_we,
    input  logic [7:0]                   mouse_data,
    input  board_status_pkg::disp_word_t core_pc,
    input  board_status_pkg::disp_word_t core_ir,
    input  logic                         btn_u,
    input  logic                         btn_d,
    input  logic                         btn_l,
    input  logic                         btn_r,
    input  logic                         btn_c,
    output board_status_pkg::disp_word_t disp_word
);

    // mouse in the upper half, keyboard in the lower, newest byte lowest
    board_status_pkg::disp_word_t history;

    always_ff @(posedge core_clk) begin
        if (!core_rst_x) begin
            history <= '0;
        end else begin
            if (kbd_we) begin
                history[15:8] <= history[7:0];
                history[7:0]  <= kbd_data;
            end
            if (mouse_we) begin
                history[31:24] <= history[23:16];
                history[23:16] <= mouse_data;
            end
        end
    end

    always_comb begin
        if (btn_u || btn_d || btn_c) begin
            disp_word = '0;
        end else if (btn_l) begin
            disp_word = core_pc;
        end else if (btn_r) begin
            disp_word = core_ir;
        end else begin
            disp_word = history;
        end
    end

endmodule

/* design/seg_digit_scan.sv */
/*
 * seven-segment scan sequencer
 * steps through the eight digits once per scan slot, registers the
 * anode pattern and nibble for each digit, and tracks the loading
 * phase and the position of the scrolling banner
 */
`timescale 1ns/1ns

module seg_digit_scan #(
    parameter int SCAN_CYCLES      = 16000,
    parameter int LOAD_STEP_CYCLES = 2 ** 25
) (
    input  logic                         core_clk,
    input  logic                         core_rst_x,
    input  board_status_pkg::disp_word_t disp_word,
    input  logic                         init_start,
    input  logic                         init_done,
    seg_scan_if.scan                     scan
);

    localparam int SCAN_W = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;
    localparam int STEP_W = (LOAD_STEP_CYCLES > 1) ? $clog2(LOAD_STEP_CYCLES) : 1;

    logic [SCAN_W-1:0]        scan_cnt;
    logic [STEP_W-1:0]        step_cnt;
    logic                     slot_end;
    board_status_pkg::digit_t next_digit;

    assign slot_end   = (scan_cnt == SCAN_W'(SCAN_CYCLES - 1));
    assign next_digit = board_status_pkg::digit_t'(scan.digit + 3'd1);

    // slot timer
    always_ff @(posedge core_clk) begin
        if (!core_rst_x || slot_end) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // digit k pulls anode k low and shows word bits 4k+3..4k
    always_ff @(posedge core_clk) begin
        if (!core_rst_x) begin
            scan.digit  <= '1;
            scan.an     <= '1;
            scan.nibble <= '0;
        end else if (slot_end) begin
            scan.digit  <= next_digit;
            scan.an     <= ~(board_status_pkg::anode_t'(1) << next_digit);
            scan.nibble <= disp_word[{next_digit, 2'b00} +: 4];
        end
    end

    // loading runs from init_start until memory init is done
    always_ff @(posedge core_clk) begin
        if (!core_rst_x) begin
            scan.loading <= 1'b0;
        end else if (!scan.loading && init_start && !init_done) begin
            scan.loading <= 1'b1;
        end else if (init_done) begin
            scan.loading <= 1'b0;
        end
    end

    // scroll one banner step on entry, then every LOAD_STEP_CYCLES
    always_ff @(posedge core_clk) begin
        if (!core_rst_x) begin
            step_cnt      <= '0;
            scan.load_pos <= '0;
        end else if (!scan.loading) begin
            step_cnt <= '0;
        end else begin
            if (step_cnt == STEP_W'(LOAD_STEP_CYCLES - 1)) begin
                step_cnt <= '0;
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
            if (step_cnt == '0) begin
                scan.load_pos <= scan.load_pos + 4'd1;
            end
        end
    end

endmodule

/* design/seg_glyph_driver.sv */
/*
 * seven-segment glyph driver
 * picks the glyph for the active digit from the loading banner, the
 * start banner or the hex font, and registers it active low
 */
`timescale 1ns/1ns

module seg_glyph_driver (
    input  logic                   core_clk,
    input  logic                   core_rst_x,
    input  logic                   init_done,
    seg_scan_if.drive              scan,
    output board_status_pkg::seg_t seg
);

    board_status_pkg::seg_t glyph;
    logic [3:0]             banner_idx;

    // banner window slides left as load_pos grows, wraps at sixteen
    assign banner_idx = scan.load_pos + 4'd7 - {1'b0, scan.digit};

    always_comb begin
        if (scan.loading) begin
            glyph = board_status_pkg::LOAD_BANNER[banner_idx];
        end else if (!init_done) begin
            glyph = board_status_pkg::INIT_BANNER[scan.digit];
        end else begin
            glyph = board_status_pkg::HEX_FONT[scan.nibble];
        end
    end

    // segments are common anode, so a lit segment is driven low
    always_ff @(posedge core_clk) begin
        if (!core_rst_x) begin
            seg <= '1;
        end else begin
            seg <= ~glyph;
        end
    end

endmodule

/* design/seg_scan_if.sv */
/*
 * seven-segment scan slot
 * carries the active digit, its anode pattern and nibble, and the
 * loading banner state from the scan sequencer to the glyph driver
 */
`timescale 1ns/1ns

interface seg_scan_if;

    board_status_pkg::digit_t  digit;
    board_status_pkg::anode_t  an;
    board_status_pkg::nibble_t nibble;
    // loading banner active
    logic                      loading;
    // banner scroll position
    logic [3:0]                load_pos;

    modport scan (
        output digit,
        output an,
        output nibble,
        output loading,
        output load_pos
    );

    modport drive (
        input digit,
        input an,
        input nibble,
        input loading,
        input load_pos
    );

endinterface

/* design/status_display_top.sv */
/*
 * front-panel status unit
 * eight-digit multiplexed seven-segment display with hex, banner and
 * loading modes, button word selection, RGB status LED and heartbeat
 */
`timescale 1ns/1ns

module status_display_top #(
    parameter int SCAN_CYCLES      = 16000,
    parameter int LOAD_STEP_CYCLES = 2 ** 25,
    parameter int HEARTBEAT_CYCLES = 32000000
) (
    input  logic                         core_clk,
    input  logic                         core_rst_x,
    input  logic                         init_start,
    input  logic                         init_done,
    input  board_status_pkg::priv_t      priv,
    input  logic                         breathe_en,
    input  logic                         kbd_we,
    input  logic [7:0]                   kbd_data,
    input  logic                         mouse_we,
    input  logic [7:0]                   mouse_data,
    input  board_status_pkg::disp_word_t core_pc,
    input  board_status_pkg::disp_word_t core_ir,
    input  logic                         btn_u,
    input  logic                         btn_d,
    input  logic                         btn_l,
    input  logic                         btn_r,
    input  logic                         btn_c,
    output board_status_pkg::seg_t       seg,
    output board_status_pkg::anode_t     an,
    output logic                         led_heartbeat,
    output board_status_pkg::rgb_t       led_rgb
);

    board_status_pkg::disp_word_t disp_word;

    seg_scan_if scan_bus ();

    key_history_select i_key_history_select (
        .core_clk   (core_clk),
        .core_rst_x (core_rst_x),
        .kbd_we     (kbd_we),
        .kbd_data   (kbd_data),
        .mouse_we   (mouse_we),
        .mouse_data (mouse_data),
        .core_pc    (core_pc),
        .core_ir    (core_ir),
        .btn_u      (btn_u),
        .btn_d      (btn_d),
        .btn_l      (btn_l),
        .btn_r      (btn_r),
        .btn_c      (btn_c),
        .disp_word  (disp_word)
    );

    seg_digit_scan #(
        .SCAN_CYCLES      (SCAN_CYCLES),
        .LOAD_STEP_CYCLES (LOAD_STEP_CYCLES)
    ) i_seg_digit_scan (
        .core_clk   (core_clk),
        .core_rst_x (core_rst_x),
        .disp_word  (disp_word),
        .init_start (init_start),
        .init_done  (init_done),
        .scan       (scan_bus.scan)
    );

    // anodes leave the unit straight from the sequencer
    assign an = scan_bus.an;

    seg_glyph_driver i_seg_glyph_driver (
        .core_clk   (core_clk),
        .core_rst_x (core_rst_x),
        .init_done  (init_done),
        .scan       (scan_bus.drive),
        .seg        (seg)
    );

    status_led_ctrl #(
        .HEARTBEAT_CYCLES (HEARTBEAT_CYCLES)
    ) i_status_led_ctrl (
        .core_clk      (core_clk),
        .core_rst_x    (core_rst_x),
        .init_done     (init_done),
        .priv          (priv),
        .breathe_en    (breathe_en),
        .led_heartbeat (led_heartbeat),
        .led_rgb       (led_rgb)
    );

endmodule

/* design/status_led_ctrl.sv */
/*
 * status LED controller
 * heartbeat toggle, three-channel breathing PWM for the RGB LED and a
 * blinking privilege colour once the core is running
 */
`timescale 1ns/1ns

module status_led_ctrl #(
    parameter int HEARTBEAT_CYCLES = 32000000
) (
    input  logic                    core_clk,
    input  logic                    core_rst_x,
    input  logic                    init_done,
    input  board_status_pkg::priv_t priv,
    input  logic                    breathe_en,
    output logic                    led_heartbeat,
    output board_status_pkg::rgb_t  led_rgb
);

    localparam int PWM_W   = board_status_pkg::PWM_W;
    localparam int PHASE_W = PWM_W + 1;
    localparam int HB_W    = (HEARTBEAT_CYCLES > 1) ? $clog2(HEARTBEAT_CYCLES) : 1;

    typedef logic [PHASE_W-1:0] phase_t;

    // channel order blue, green, red
    localparam phase_t PHASE_INIT [3] = '{13'd0, 13'd64, 13'd512};
    localparam phase_t PHASE_STEP [3] = '{13'd2, 13'd3, 13'd5};

    logic [HB_W-1:0]                      hb_cnt;
    logic [PWM_W-1:0]                     ramp;
    logic [board_status_pkg::BLINK_W-1:0] blink_cnt;
    phase_t                               phase [3];
    board_status_pkg::rgb_t               breathe_rgb;
    board_status_pkg::rgb_t               priv_rgb;
    board_status_pkg::rgb_t               rgb_next;

    // top phase bit selects the rising or falling half of the breath
    function automatic logic breath_level(input phase_t ph, input logic [PWM_W-1:0] level);
        if (ph[PWM_W]) begin
            return ph[PWM_W-1:0] < level;
        end
        return ph[PWM_W-1:0] >= level;
    endfunction

    always_ff @(posedge core_clk) begin
        if (!core_rst_x) begin
            hb_cnt        <= '0;
            led_heartbeat <= 1'b0;
        end else if (hb_cnt == HB_W'(HEARTBEAT_CYCLES - 1)) begin
            hb_cnt        <= '0;
            led_heartbeat <= ~led_heartbeat;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;
        end
    end

    // phases move on once per full ramp
    always_ff @(posedge core_clk) begin
        if (!core_rst_x) begin
            ramp      <= '0;
            blink_cnt <= '0;
            for (int i = 0; i < 3; i++) begin
                phase[i] <= PHASE_INIT[i];
            end
        end else begin
            ramp      <= ramp + 1'b1;
            blink_cnt <= blink_cnt + 1'b1;
            if (ramp == '0) begin
                for (int i = 0; i < 3; i++) begin
                    phase[i] <= phase[i] + PHASE_STEP[i];
                end
            end
        end
    end

    always_comb begin
        breathe_rgb.blue  = breath_level(phase[0], ramp);
        breathe_rgb.green = breath_level(phase[1], ramp);
        breathe_rgb.red   = breath_level(phase[2], ramp);
    end

    // user blue, supervisor green, machine red
    always_comb begin
        priv_rgb = '0;
        case (priv)
            board_status_pkg::PRIV_U: priv_rgb.blue  = 1'b1;
            board_status_pkg::PRIV_S: priv_rgb.green = 1'b1;
            board_status_pkg::PRIV_M: priv_rgb.red   = 1'b1;
            default:                  priv_rgb       = '0;
        endcase
    end

    // short flash once per blink period
    always_comb begin
        if (breathe_en) begin
            rgb_next = breathe_rgb;
        end else if (!init_done || blink_cnt != '0) begin
            rgb_next = '0;
        end else begin
            rgb_next = priv_rgb;
        end
    end

    always_ff @(posedge core_clk) begin
        if (!core_rst_x) begin
            led_rgb <= '0;
        end else begin
            led_rgb <= rgb_next;
        end
    end

endmodule

/* verif/tb_model.svh */
/*
 * testbench reference model helpers
 * word selection, anode, glyph and privilege colour rules of the status
 * unit, and the typed compare tasks that count mismatches
 */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// btns is {up, down, left, right, centre}
function automatic board_status_pkg::disp_word_t select_word(
    input board_status_pkg::disp_word_t hist,
    input board_status_pkg::disp_word_t pc,
    input board_status_pkg::disp_word_t ir,
    input logic [4:0]                   btns
);
    if (btns[4] || btns[3] || btns[0]) begin
        return '0;
    end
    if (btns[2]) begin
        return pc;
    end
    if (btns[1]) begin
        return ir;
    end
    return hist;
endfunction

// only the enable of the active digit is low
function automatic board_status_pkg::anode_t anode_for(input board_status_pkg::digit_t d);
    board_status_pkg::anode_t a;
    for (int i = 0; i < 8; i++) begin
        a[3'(i)] = (3'(i) != d);
    end
    return a;
endfunction

function automatic board_status_pkg::nibble_t nibble_of(
    input board_status_pkg::disp_word_t word,
    input board_status_pkg::digit_t     d
);
    return board_status_pkg::nibble_t'(word >> (4 * int'(d)));
endfunction

// loading banner first, then the start banner, then hex
function automatic board_status_pkg::seg_t expected_glyph(
    input logic                      loading,
    input logic                      done,
    input board_status_pkg::digit_t  digit,
    input board_status_pkg::nibble_t nibble,
    input logic [3:0]                load_pos
);
    logic [3:0] idx;
    idx = 4'((int'(load_pos) + 7 - int'(digit)) % 16);
    if (loading) begin
        return board_status_pkg::LOAD_BANNER[idx];
    end
    if (!done) begin
        return board_status_pkg::INIT_BANNER[digit];
    end
    return board_status_pkg::HEX_FONT[nibble];
endfunction

function automatic board_status_pkg::rgb_t priv_colour(input board_status_pkg::priv_t p);
    board_status_pkg::rgb_t c;
    c.blue  = (p == board_status_pkg::PRIV_U);
    c.green = (p == board_status_pkg::PRIV_S);
    c.red   = (p == board_status_pkg::PRIV_M);
    return c;
endfunction

task automatic check_seg(input string name, input board_status_pkg::seg_t exp,
                         input board_status_pkg::seg_t act);
    if (act !== exp) begin
        err_count++;
        $display("** Error %s: seg expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_an(input string name, input board_status_pkg::anode_t exp,
                        input board_status_pkg::anode_t act);
    if (act !== exp) begin
        err_count++;
        $display("** Error %s: an expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_rgb(input string name, input board_status_pkg::rgb_t exp,
                         input board_status_pkg::rgb_t act);
    if (act !== exp) begin
        err_count++;
        $display("** Error %s: led_rgb expected %b, actual %b", name, exp, act);
    end
endtask

task automatic check_heartbeat(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        err_count++;
        $display("** Error %s: led_heartbeat expected %b, actual %b", name, exp, act);
    end
endtask

`endif

/* verif/tb_status_display.sv */
/*
 * testbench for the front-panel status unit
 * random keyboard, mouse, button and init stimulus checked each cycle
 * against a model of the display, heartbeat and status LED
 */
`timescale 1ns/1ns

module tb_status_display;

    localparam int SCAN_CYCLES      = 4;
    localparam int LOAD_STEP_CYCLES = 8;
    localparam int HEARTBEAT_CYCLES = 20;

    logic                         core_clk;
    logic                         core_rst_x;
    logic                         init_start;
    logic                         init_done;
    board_status_pkg::priv_t      priv;
    logic                         breathe_en;
    logic                         kbd_we;
    logic [7:0]                   kbd_data;
    logic                         mouse_we;
    logic [7:0]                   mouse_data;
    board_status_pkg::disp_word_t core_pc;
    board_status_pkg::disp_word_t core_ir;
    logic                         btn_u;
    logic                         btn_d;
    logic                         btn_l;
    logic                         btn_r;
    logic                         btn_c;
    board_status_pkg::seg_t       seg;
    board_status_pkg::anode_t     an;
    logic                         led_heartbeat;
    board_status_pkg::rgb_t       led_rgb;

    integer seed;
    int     err_count;
    int     fail_count;
    int     dark_run;
    string  test_name;

    // model state
    board_status_pkg::disp_word_t m_hist;
    int                           m_scan;
    board_status_pkg::digit_t     m_digit;
    board_status_pkg::anode_t     m_an;
    board_status_pkg::nibble_t    m_nibble;
    logic                         m_loading;
    int                           m_step;
    logic [3:0]                   m_load_pos;
    board_status_pkg::seg_t       m_seg;
    int                           m_hb_cnt;
    logic                         m_hb;
    logic [3:0]                   m_blink;
    board_status_pkg::rgb_t       m_rgb;

    `include "tb_model.svh"

    status_display_top #(
        .SCAN_CYCLES      (SCAN_CYCLES),
        .LOAD_STEP_CYCLES (LOAD_STEP_CYCLES),
        .HEARTBEAT_CYCLES (HEARTBEAT_CYCLES)
    ) i_dut (
        .core_clk      (core_clk),
        .core_rst_x    (core_rst_x),
        .init_start    (init_start),
        .init_done     (init_done),
        .priv          (priv),
        .breathe_en    (breathe_en),
        .kbd_we        (kbd_we),
        .kbd_data      (kbd_data),
        .mouse_we      (mouse_we),
        .mouse_data    (mouse_data),
        .core_pc       (core_pc),
        .core_ir       (core_ir),
        .btn_u         (btn_u),
        .btn_d         (btn_d),
        .btn_l         (btn_l),
        .btn_r         (btn_r),
        .btn_c         (btn_c),
        .seg           (seg),
        .an            (an),
        .led_heartbeat (led_heartbeat),
        .led_rgb       (led_rgb)
    );

    always #4 core_clk = ~core_clk;

    always @(posedge core_clk) begin
        if (!core_rst_x) begin
            m_hist     <= '0;
            m_scan     <= 0;
            m_digit    <= 3'd7;
            m_an       <= '1;
            m_nibble   <= '0;
            m_loading  <= 1'b0;
            m_step     <= 0;
            m_load_pos <= '0;
            m_seg      <= '1;
            m_hb_cnt   <= 0;
            m_hb       <= 1'b0;
            m_blink    <= '0;
            m_rgb      <= '0;
        end else begin
            if (kbd_we) begin
                m_hist[15:0] <= {m_hist[7:0], kbd_data};
            end
            if (mouse_we) begin
                m_hist[31:16] <= {m_hist[23:16], mouse_data};
            end
            // next digit takes the word as selected at the slot end
            if (m_scan == SCAN_CYCLES - 1) begin
                m_scan   <= 0;
                m_digit  <= m_digit + 3'd1;
                m_an     <= anode_for(m_digit + 3'd1);
                m_nibble <= nibble_of(select_word(m_hist, core_pc, core_ir,
                                                  {btn_u, btn_d, btn_l, btn_r, btn_c}),
                                      m_digit + 3'd1);
            end else begin
                m_scan <= m_scan + 1;
            end
            if (!m_loading && init_start && !init_done) begin
                m_loading <= 1'b1;
            end else if (init_done) begin
                m_loading <= 1'b0;
            end
            if (!m_loading) begin
                m_step <= 0;
            end else begin
                m_step <= (m_step == LOAD_STEP_CYCLES - 1) ? 0 : m_step + 1;
                if (m_step == 0) begin
                    m_load_pos <= m_load_pos + 4'd1;
                end
            end
            m_seg <= ~expected_glyph(m_loading, init_done, m_digit, m_nibble, m_load_pos);
            if (m_hb_cnt == HEARTBEAT_CYCLES - 1) begin
                m_hb_cnt <= 0;
                m_hb     <= ~m_hb;
            end else begin
                m_hb_cnt <= m_hb_cnt + 1;
            end
            m_blink <= m_blink + 4'd1;
            m_rgb   <= (init_done && m_blink == '0) ? priv_colour(priv) : '0;
        end
    end

    task automatic compare_outputs();
        check_an(test_name, m_an, an);
        check_seg(test_name, m_seg, seg);
        check_rgb(test_name, m_rgb, led_rgb);
        check_heartbeat(test_name, m_hb, led_heartbeat);
        // colour must flash at least once per blink period
        if (init_done && led_rgb == '0) begin
            dark_run++;
        end else begin
            dark_run = 0;
        end
        if (dark_run == 17) begin
            fail_count++;
            $display("Failure in %s: status LED stayed dark for more than 16 cycles", test_name);
        end
    endtask

    task automatic run_cycle(input logic start, input logic done, input logic press);
        @(posedge core_clk);
        #1;
        init_start = start;
        init_done  = done;
        kbd_we     = ($random(seed) & 3) == 0;
        kbd_data   = 8'($random(seed));
        mouse_we   = ($random(seed) & 3) == 0;
        mouse_data = 8'($random(seed));
        core_pc    = $random(seed);
        core_ir    = $random(seed);
        case ($random(seed) & 31)
            0: priv = board_status_pkg::PRIV_U;
            1: priv = board_status_pkg::PRIV_S;
            2: priv = board_status_pkg::PRIV_M;
            default: ;
        endcase
        btn_u = press && (($random(seed) & 7) == 0);
        btn_d = press && (($random(seed) & 7) == 0);
        btn_l = press && (($random(seed) & 3) == 0);
        btn_r = press && (($random(seed) & 3) == 0);
        btn_c = press && (($random(seed) & 7) == 0);
        @(negedge core_clk);
        compare_outputs();
    endtask

    task automatic wait_anode_active(input int limit);
        int n;
        n = 0;
        while (an === '1 && n < limit) begin
            @(negedge core_clk);
            compare_outputs();
            n++;
        end
        if (an === '1) begin
            fail_count++;
            $display("Timeout in %s: no digit enabled within %0d cycles", test_name, limit);
        end
    endtask

    task automatic wait_heartbeat_toggle(input int limit);
        logic start_level;
        int   n;
        start_level = led_heartbeat;
        n = 0;
        while (led_heartbeat === start_level && n < limit) begin
            @(negedge core_clk);
            compare_outputs();
            n++;
        end
        if (led_heartbeat === start_level) begin
            fail_count++;
            $display("Timeout in %s: heartbeat did not toggle within %0d cycles", test_name, limit);
        end
    endtask

    initial begin
        seed       = 44235;
        err_count  = 0;
        fail_count = 0;
        dark_run   = 0;
        test_name  = "reset";
        core_clk   = 1'b0;
        core_rst_x = 1'b0;
        init_start = 1'b0;
        init_done  = 1'b0;
        priv       = board_status_pkg::PRIV_M;
        breathe_en = 1'b0;
        kbd_we     = 1'b0;
        kbd_data   = '0;
        mouse_we   = 1'b0;
        mouse_data = '0;
        core_pc    = '0;
        core_ir    = '0;
        btn_u      = 1'b0;
        btn_d      = 1'b0;
        btn_l      = 1'b0;
        btn_r      = 1'b0;
        btn_c      = 1'b0;
        repeat (3) @(posedge core_clk);
        #1;
        core_rst_x = 1'b1;
        @(negedge core_clk);
        check_an(test_name, 8'hFF, an);
        check_seg(test_name, 8'hFF, seg);
        check_heartbeat(test_name, 1'b0, led_heartbeat);
        check_rgb(test_name, 3'b000, led_rgb);
        compare_outputs();
        wait_anode_active(2 * SCAN_CYCLES);
        test_name = "init_banner";
        repeat (40) run_cycle(1'b0, 1'b0, 1'b0);
        test_name = "loading";
        run_cycle(1'b1, 1'b0, 1'b0);
        repeat (150) run_cycle(1'b0, 1'b0, 1'b0);
        test_name = "hex_history";
        repeat (200) run_cycle(1'b0, 1'b1, 1'b0);
        test_name = "buttons";
        repeat (300) run_cycle(1'b0, 1'b1, 1'b1);
        test_name = "heartbeat";
        wait_heartbeat_toggle(HEARTBEAT_CYCLES + 2);
        $display("checks done: %0d value errors, %0d other failures", err_count, fail_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
